// ==== hw/rx_bert_params.svh ====
//--------------------------------------------------
// Lane geometry, BERT access widths and the
// access register map
//--------------------------------------------------
`ifndef RX_BERT_PARAMS_SVH
`define RX_BERT_PARAMS_SVH

// FIFO word geometry
`define RX_LANES       4        // Lanes per FIFO read word
`define LANE_W         8        // Bits per lane per beat

// Access port
`define BERT_ADDR_W    6        // Access address width
`define BERT_DATA_W    32       // Access data width
`define ERR_CNT_W      16       // Saturating error counter

// Register map
`define BERT_CTRL_ADDR 6'h00    // Start, reset, pattern, lane
`define BERT_ERR_ADDR  6'h01    // Error count
`define BERT_BITS_ADDR 6'h02    // Checked-bit count
`define BERT_STAT_ADDR 6'h03    // Run and sticky error

`endif

// ==== hw/rx_bert_pkg.sv ====
//--------------------------------------------------
// Shared types of the RX read-side adapter and
// its BERT checker
//--------------------------------------------------
`default_nettype none

`include "rx_bert_params.svh"

package rx_bert_pkg;

  typedef logic [`RX_LANES*`LANE_W-1:0]   fifo_word_t;  // One FIFO read word
  typedef logic [`LANE_W-1:0]             lane_data_t;  // One lane beat
  typedef logic [$clog2(`RX_LANES)-1:0]   lane_sel_t;   // Lane index

  typedef enum logic
  {
    PRBS7  = 1'b0,                                       // x^7 + x^6 + 1
    PRBS15 = 1'b1                                        // x^15 + x^14 + 1
  } ptrn_sel_e;

  typedef logic [`BERT_ADDR_W-1:0]        bert_addr_t;  // Access address
  typedef logic [`BERT_DATA_W-1:0]        bert_word_t;  // Access data
  typedef logic [`ERR_CNT_W-1:0]          err_cnt_t;    // Saturates at all ones
  typedef logic [`BERT_DATA_W-1:0]        bit_cnt_t;    // Wraps

endpackage

`default_nettype wire

// ==== hw/rx_bert_acc_decode.sv ====
//--------------------------------------------------
// BERT access decode: accept test, control
// register fields, start/reset pulses, read strobe
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "rx_bert_params.svh"

module rx_bert_acc_decode (
  input  logic                    m_rd_clk_g,       // Gated FIFO read clock
  input  logic                    rxrd_fifo_rstn,   // Async reset, active low
  input  logic                    i_bert_acc_req,   // Access request
  input  logic                    i_bert_acc_rdwr,  // 1 write, 0 read
  input  rx_bert_pkg::bert_addr_t i_bert_acc_addr,  // Access address
  input  rx_bert_pkg::bert_word_t i_bert_wdata,     // Write data
  input  logic                    i_acc_busy,       // Pending from read-back
  output logic                    o_acc_accept,     // Access taken this edge
  output logic                    o_rd_strobe,      // Read capture cycle
  output rx_bert_pkg::bert_addr_t o_rd_addr,        // Latched read address
  output rx_bert_pkg::bert_word_t o_ctrl_word,      // Stored control view
  output logic                    o_start_pulse,    // Checker start
  output logic                    o_rst_pulse,      // Checker clear
  output rx_bert_pkg::lane_sel_t  o_lane_sel,       // Checked lane
  output rx_bert_pkg::ptrn_sel_e  o_ptrn_sel        // Checked pattern
);

  logic                    acc_accept;
  logic                    ctrl_wr;
  logic                    rd_strobe_ff;
  logic                    start_ff;
  logic                    rst_ff;
  rx_bert_pkg::lane_sel_t  lane_sel_ff;
  rx_bert_pkg::ptrn_sel_e  ptrn_sel_ff;
  rx_bert_pkg::bert_addr_t rd_addr_ff;

  // Only place the accept condition lives
  assign acc_accept = i_bert_acc_req & ~i_acc_busy;
  assign ctrl_wr    = acc_accept & i_bert_acc_rdwr &
                      (i_bert_acc_addr == `BERT_CTRL_ADDR);

  //--------------------------------------------------
  // Control fields and one-cycle pulses
  //--------------------------------------------------
  always_ff @(posedge m_rd_clk_g or negedge rxrd_fifo_rstn)
  begin
    if (!rxrd_fifo_rstn)
    begin
      start_ff     <= 1'b0;
      rst_ff       <= 1'b0;
      rd_strobe_ff <= 1'b0;
      lane_sel_ff  <= '0;
      ptrn_sel_ff  <= rx_bert_pkg::PRBS7;
    end
    else
    begin
      start_ff     <= ctrl_wr & i_bert_wdata[0];         // Self-clearing
      rst_ff       <= ctrl_wr & i_bert_wdata[1];         // Self-clearing
      rd_strobe_ff <= acc_accept & ~i_bert_acc_rdwr;     // Cycle after accept
      if (ctrl_wr)
      begin
        lane_sel_ff <= i_bert_wdata[5:4];
        ptrn_sel_ff <= rx_bert_pkg::ptrn_sel_e'(i_bert_wdata[2]);
      end
    end
  end

  // Read address, only sampled at a read accept
  always_ff @(posedge m_rd_clk_g)
  begin
    if (acc_accept && !i_bert_acc_rdwr)
      rd_addr_ff <= i_bert_acc_addr;
  end

  assign o_acc_accept  = acc_accept;
  assign o_rd_strobe   = rd_strobe_ff;
  assign o_rd_addr     = rd_addr_ff;
  assign o_start_pulse = start_ff;
  assign o_rst_pulse   = rst_ff;
  assign o_lane_sel    = lane_sel_ff;
  assign o_ptrn_sel    = ptrn_sel_ff;

  // Start and reset read back as zero
  assign o_ctrl_word = {{(`BERT_DATA_W-6){1'b0}}, lane_sel_ff, 1'b0, ptrn_sel_ff, 2'b00};

endmodule

`default_nettype wire

// ==== hw/rx_bert_checker.sv ====
//--------------------------------------------------
// Self-seeding PRBS7/PRBS15 checker on one lane
// of the FIFO word, with bit and error counters
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "rx_bert_params.svh"

module rx_bert_checker (
  input  logic                    m_rd_clk_g,      // Gated FIFO read clock
  input  logic                    rxrd_fifo_rstn,  // Async reset, active low
  input  rx_bert_pkg::fifo_word_t i_fifo_rdata,    // FIFO read word
  input  logic                    i_start_pulse,   // Start checking
  input  logic                    i_rst_pulse,     // Clear everything
  input  rx_bert_pkg::lane_sel_t  i_lane_sel,      // Lane under test
  input  rx_bert_pkg::ptrn_sel_e  i_ptrn_sel,      // Expected pattern
  output rx_bert_pkg::err_cnt_t   o_err_cnt,       // Bit errors
  output rx_bert_pkg::bit_cnt_t   o_bit_cnt,       // Checked bits
  output logic                    o_run,           // Checker running
  output logic                    o_biterr         // Sticky error
);

  rx_bert_pkg::lane_data_t lane_beat;
  logic [3:0]              seed_len;
  logic [14:0]             hist_ff;                // Bit 0 newest
  logic [14:0]             hist_nxt;
  logic [3:0]              seed_cnt_ff;
  logic [3:0]              seed_nxt;
  logic [3:0]              err_inc;                // Up to LANE_W per beat
  logic [3:0]              bit_inc;
  logic [`ERR_CNT_W:0]     err_sum;
  rx_bert_pkg::err_cnt_t   err_sat;
  rx_bert_pkg::err_cnt_t   err_cnt_ff;
  rx_bert_pkg::bit_cnt_t   bit_cnt_ff;
  logic                    run_ff;
  logic                    biterr_ff;

  assign lane_beat = i_fifo_rdata[i_lane_sel*`LANE_W +: `LANE_W];
  assign seed_len  = (i_ptrn_sel == rx_bert_pkg::PRBS7) ? 4'd7 : 4'd15;

  //--------------------------------------------------
  // Bit walk over one beat, bit 0 first
  //--------------------------------------------------
  always_comb
  begin
    logic exp_bit;
    hist_nxt = hist_ff;
    seed_nxt = seed_cnt_ff;
    err_inc  = '0;
    bit_inc  = '0;
    for (int i = 0; i < `LANE_W; i++)
    begin
      // Taps are the bits 6/7 or 14/15 positions back
      if (i_ptrn_sel == rx_bert_pkg::PRBS7)
        exp_bit = hist_nxt[5] ^ hist_nxt[6];
      else
        exp_bit = hist_nxt[13] ^ hist_nxt[14];
      if (seed_nxt < seed_len)
        seed_nxt = seed_nxt + 4'd1;                    // Still seeding
      else
      begin
        bit_inc = bit_inc + 4'd1;
        if (lane_beat[i] != exp_bit)
          err_inc = err_inc + 4'd1;
      end
      hist_nxt = {hist_nxt[13:0], lane_beat[i]};       // Always shifted in
    end
  end

  // Saturating error add
  assign err_sum = {1'b0, err_cnt_ff} + {{(`ERR_CNT_W-3){1'b0}}, err_inc};
  assign err_sat = err_sum[`ERR_CNT_W] ? '1 : err_sum[`ERR_CNT_W-1:0];

  //--------------------------------------------------
  // State update, reset over start over run
  //--------------------------------------------------
  always_ff @(posedge m_rd_clk_g or negedge rxrd_fifo_rstn)
  begin
    if (!rxrd_fifo_rstn)
    begin
      run_ff      <= 1'b0;
      biterr_ff   <= 1'b0;
      err_cnt_ff  <= '0;
      bit_cnt_ff  <= '0;
      seed_cnt_ff <= '0;
      hist_ff     <= '0;
    end
    else if (i_rst_pulse)
    begin
      run_ff      <= 1'b0;                             // Stops too
      biterr_ff   <= 1'b0;
      err_cnt_ff  <= '0;
      bit_cnt_ff  <= '0;
      seed_cnt_ff <= '0;
      hist_ff     <= '0;
    end
    else if (i_start_pulse)
    begin
      run_ff      <= 1'b1;
      biterr_ff   <= 1'b0;
      err_cnt_ff  <= '0;
      bit_cnt_ff  <= '0;
      seed_cnt_ff <= '0;                               // Reseed from stream
      hist_ff     <= '0;
    end
    else if (run_ff)
    begin
      hist_ff     <= hist_nxt;
      seed_cnt_ff <= seed_nxt;
      err_cnt_ff  <= err_sat;
      bit_cnt_ff  <= bit_cnt_ff + {{($bits(rx_bert_pkg::bit_cnt_t)-4){1'b0}}, bit_inc};
      biterr_ff   <= biterr_ff | (err_inc != 4'd0);
    end
  end

  assign o_err_cnt = err_cnt_ff;
  assign o_bit_cnt = bit_cnt_ff;
  assign o_run     = run_ff;
  assign o_biterr  = biterr_ff;

endmodule

`default_nettype wire

// ==== hw/rx_bert_readback.sv ====
//--------------------------------------------------
// BERT read-back: register select, read-data
// register and the access pending flag
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "rx_bert_params.svh"

module rx_bert_readback (
  input  logic                    m_rd_clk_g,          // Gated FIFO read clock
  input  logic                    rxrd_fifo_rstn,      // Async reset, active low
  input  logic                    i_acc_accept,        // Access taken this edge
  input  logic                    i_rd_strobe,         // Capture read data
  input  rx_bert_pkg::bert_addr_t i_rd_addr,           // Latched read address
  input  rx_bert_pkg::bert_word_t i_ctrl_word,         // Control register view
  input  rx_bert_pkg::err_cnt_t   i_err_cnt,           // Checker error count
  input  rx_bert_pkg::bit_cnt_t   i_bit_cnt,           // Checker bit count
  input  logic                    i_run,               // Checker running
  input  logic                    i_biterr,            // Sticky error
  output rx_bert_pkg::bert_word_t o_bert_rdata,        // Read data to host
  output logic                    o_bert_acc_rq_pend   // Access in progress
);

  rx_bert_pkg::bert_word_t rd_mux;
  rx_bert_pkg::bert_word_t rdata_ff;
  logic                    pend_ff;

  // Register select, zero-extended
  always_comb
  begin
    case (i_rd_addr)
      `BERT_CTRL_ADDR: rd_mux = i_ctrl_word;
      `BERT_ERR_ADDR:  rd_mux = {{(`BERT_DATA_W-`ERR_CNT_W){1'b0}}, i_err_cnt};
      `BERT_BITS_ADDR: rd_mux = i_bit_cnt;
      `BERT_STAT_ADDR: rd_mux = {{(`BERT_DATA_W-2){1'b0}}, i_biterr, i_run};
      default:         rd_mux = '0;                    // Unmapped
    endcase
  end

  //--------------------------------------------------
  // Read data and pending, one cycle per access
  //--------------------------------------------------
  always_ff @(posedge m_rd_clk_g or negedge rxrd_fifo_rstn)
  begin
    if (!rxrd_fifo_rstn)
    begin
      rdata_ff <= '0;
      pend_ff  <= 1'b0;
    end
    else
    begin
      if (i_rd_strobe)
        rdata_ff <= rd_mux;                            // Held until next read
      if (i_acc_accept)
        pend_ff <= 1'b1;
      else if (pend_ff)
        pend_ff <= 1'b0;                               // Clears with the capture
    end
  end

  assign o_bert_rdata       = rdata_ff;
  assign o_bert_acc_rq_pend = pend_ff;

endmodule

`default_nettype wire

// ==== hw/rx_rd_adapter_top.sv ====
//--------------------------------------------------
// RX read-clock side of the adapter: FIFO-mode
// output register and the RX BERT checker
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rx_rd_adapter_top (
  input  logic                    m_rd_clk_g,          // Gated FIFO read clock
  input  logic                    rxrd_fifo_rstn,      // Async reset, active low
  input  rx_bert_pkg::fifo_word_t i_fifo_rdata,        // RX FIFO read word
  output rx_bert_pkg::fifo_word_t o_data_out_f,        // FIFO data to MAC
  input  logic                    i_bert_acc_req,      // BERT access request
  input  logic                    i_bert_acc_rdwr,     // 1 write, 0 read
  input  rx_bert_pkg::bert_addr_t i_bert_acc_addr,     // BERT access address
  input  rx_bert_pkg::bert_word_t i_bert_wdata,        // BERT write data
  output rx_bert_pkg::bert_word_t o_bert_rdata,        // BERT read data
  output logic                    o_bert_acc_rq_pend,  // Access pending
  output logic                    o_rxbert_run,        // Checker running
  output logic                    o_rxbert_biterr      // Sticky bit error
);

  rx_bert_pkg::fifo_word_t data_out_f_ff;
  logic                    acc_accept;
  logic                    rd_strobe;
  rx_bert_pkg::bert_addr_t rd_addr;
  rx_bert_pkg::bert_word_t ctrl_word;
  logic                    start_pulse;
  logic                    rst_pulse;
  rx_bert_pkg::lane_sel_t  lane_sel;
  rx_bert_pkg::ptrn_sel_e  ptrn_sel;
  rx_bert_pkg::err_cnt_t   err_cnt;
  rx_bert_pkg::bit_cnt_t   bit_cnt;

  //--------------------------------------------------
  // FIFO-mode output register
  //--------------------------------------------------
  always_ff @(posedge m_rd_clk_g or negedge rxrd_fifo_rstn)
  begin
    if (!rxrd_fifo_rstn)
      data_out_f_ff <= '0;
    else
      data_out_f_ff <= i_fifo_rdata;                   // One cycle to MAC
  end

  assign o_data_out_f = data_out_f_ff;

  // Access decode, busy comes back from read-back
  rx_bert_acc_decode u_acc_decode (
    .m_rd_clk_g      (m_rd_clk_g),
    .rxrd_fifo_rstn  (rxrd_fifo_rstn),
    .i_bert_acc_req  (i_bert_acc_req),
    .i_bert_acc_rdwr (i_bert_acc_rdwr),
    .i_bert_acc_addr (i_bert_acc_addr),
    .i_bert_wdata    (i_bert_wdata),
    .i_acc_busy      (o_bert_acc_rq_pend),
    .o_acc_accept    (acc_accept),
    .o_rd_strobe     (rd_strobe),
    .o_rd_addr       (rd_addr),
    .o_ctrl_word     (ctrl_word),
    .o_start_pulse   (start_pulse),
    .o_rst_pulse     (rst_pulse),
    .o_lane_sel      (lane_sel),
    .o_ptrn_sel      (ptrn_sel)
  );

  // Checker sees the unregistered FIFO word
  rx_bert_checker u_checker (
    .m_rd_clk_g     (m_rd_clk_g),
    .rxrd_fifo_rstn (rxrd_fifo_rstn),
    .i_fifo_rdata   (i_fifo_rdata),
    .i_start_pulse  (start_pulse),
    .i_rst_pulse    (rst_pulse),
    .i_lane_sel     (lane_sel),
    .i_ptrn_sel     (ptrn_sel),
    .o_err_cnt      (err_cnt),
    .o_bit_cnt      (bit_cnt),
    .o_run          (o_rxbert_run),
    .o_biterr       (o_rxbert_biterr)
  );

  rx_bert_readback u_readback (
    .m_rd_clk_g         (m_rd_clk_g),
    .rxrd_fifo_rstn     (rxrd_fifo_rstn),
    .i_acc_accept       (acc_accept),
    .i_rd_strobe        (rd_strobe),
    .i_rd_addr          (rd_addr),
    .i_ctrl_word        (ctrl_word),
    .i_err_cnt          (err_cnt),
    .i_bit_cnt          (bit_cnt),
    .i_run              (o_rxbert_run),
    .i_biterr           (o_rxbert_biterr),
    .o_bert_rdata       (o_bert_rdata),
    .o_bert_acc_rq_pend (o_bert_acc_rq_pend)
  );

endmodule

`default_nettype wire

// ==== sim/rx_rd_adapter_assertions.sv ====
//--------------------------------------------------
// Concurrent checks on the access handshake, the
// error counter and the FIFO output in reset
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rx_rd_adapter_assertions (
  input logic                    m_rd_clk_g,      // Gated FIFO read clock
  input logic                    rxrd_fifo_rstn,  // Async reset, active low
  input logic                    i_pend,          // Access pending
  input logic                    i_start_pulse,   // Checker start
  input logic                    i_rst_pulse,     // Checker clear
  input rx_bert_pkg::err_cnt_t   i_err_cnt,       // Checker error count
  input rx_bert_pkg::fifo_word_t i_data_out_f     // FIFO data to MAC
);

  // One pending cycle per access
  pend_single_a: assert property (@(posedge m_rd_clk_g) disable iff (!rxrd_fifo_rstn)
    i_pend |=> !i_pend)
    else $error("access pending stayed high for two cycles");

  // Only a start or reset may lower the count
  err_mono_a: assert property (@(posedge m_rd_clk_g) disable iff (!rxrd_fifo_rstn)
    !(i_start_pulse || i_rst_pulse) |=> (i_err_cnt >= $past(i_err_cnt)))
    else $error("error count went down without start or reset");

  // Output register cleared while reset held
  data_rst_a: assert property (@(posedge m_rd_clk_g)
    !rxrd_fifo_rstn |-> (i_data_out_f == '0))
    else $error("FIFO output not zero in reset");

endmodule

bind rx_rd_adapter_top rx_rd_adapter_assertions u_sva (
  .m_rd_clk_g     (m_rd_clk_g),
  .rxrd_fifo_rstn (rxrd_fifo_rstn),
  .i_pend         (o_bert_acc_rq_pend),
  .i_start_pulse  (start_pulse),
  .i_rst_pulse    (rst_pulse),
  .i_err_cnt      (err_cnt),
  .i_data_out_f   (o_data_out_f)
);

`default_nettype wire

// ==== sim/rx_rd_adapter_tb.sv ====
//--------------------------------------------------
// Testbench for the RX read-side adapter: PRBS
// stimulus, BERT access tasks, reference model
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "rx_bert_params.svh"

module rx_rd_adapter_tb;

  localparam int TMO       = 20;                     // Cycles per handshake wait
  localparam int LOG_DEPTH = 1024;                   // Lane beats kept for the model

  logic                    m_rd_clk_g = 1'b0;
  logic                    rxrd_fifo_rstn;
  rx_bert_pkg::fifo_word_t i_fifo_rdata;
  rx_bert_pkg::fifo_word_t o_data_out_f;
  logic                    i_bert_acc_req;
  logic                    i_bert_acc_rdwr;
  rx_bert_pkg::bert_addr_t i_bert_acc_addr;
  rx_bert_pkg::bert_word_t i_bert_wdata;
  rx_bert_pkg::bert_word_t o_bert_rdata;
  logic                    o_bert_acc_rq_pend;
  logic                    o_rxbert_run;
  logic                    o_rxbert_biterr;

  rx_bert_pkg::lane_data_t lane_log [LOG_DEPTH];     // Checked-lane beat per cycle
  int                      beat_cnt   = 0;
  logic [14:0]             gen_hist   = 15'h5a3c;    // PRBS generator, bit 0 newest
  int                      gen_order  = 7;
  int                      gen_lane   = 0;
  bit                      prbs_on    = 1'b0;
  bit                      flip_on    = 1'b0;        // Inject channel errors
  int                      n_checks   = 0;
  int                      n_errors   = 0;
  int                      err_mark   = 0;

  always #2 m_rd_clk_g = ~m_rd_clk_g;               // 4 ns period

  rx_rd_adapter_top uut (
    .m_rd_clk_g         (m_rd_clk_g),
    .rxrd_fifo_rstn     (rxrd_fifo_rstn),
    .i_fifo_rdata       (i_fifo_rdata),
    .o_data_out_f       (o_data_out_f),
    .i_bert_acc_req     (i_bert_acc_req),
    .i_bert_acc_rdwr    (i_bert_acc_rdwr),
    .i_bert_acc_addr    (i_bert_acc_addr),
    .i_bert_wdata       (i_bert_wdata),
    .o_bert_rdata       (o_bert_rdata),
    .o_bert_acc_rq_pend (o_bert_acc_rq_pend),
    .o_rxbert_run       (o_rxbert_run),
    .o_rxbert_biterr    (o_rxbert_biterr)
  );

  //--------------------------------------------------
  // Reference model of the checker rule
  //--------------------------------------------------
  function automatic void prbs_ref_check(input int first, input int last, input int k,
                                         output rx_bert_pkg::err_cnt_t err,
                                         output rx_bert_pkg::bit_cnt_t bits,
                                         output logic flag);
    logic bq[$];
    logic exp_bit;
    err  = '0;
    bits = '0;
    flag = 1'b0;
    for (int n = first; n <= last; n++)
      for (int i = 0; i < `LANE_W; i++)
        bq.push_back(lane_log[n][i]);                // Bit 0 of a beat first
    for (int j = k; j < bq.size(); j++)              // First k bits only seed
    begin
      exp_bit = bq[j-k+1] ^ bq[j-k];                 // Taps k-1 and k back
      bits++;
      if (bq[j] !== exp_bit)
      begin
        if (err != '1)
          err++;                                     // Saturates
        flag = 1'b1;
      end
    end
  endfunction

  //--------------------------------------------------
  // Compare tasks
  //--------------------------------------------------
  task automatic note_fail(input string msg);
    $display("%s", msg);
    n_errors++;
  endtask

  task automatic check_word(input string name, input rx_bert_pkg::fifo_word_t got,
                            input rx_bert_pkg::fifo_word_t exp);
    n_checks++;
    if (got !== exp)
      note_fail($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic check_reg(input string name, input rx_bert_pkg::bert_word_t got,
                           input rx_bert_pkg::bert_word_t exp);
    n_checks++;
    if (got !== exp)
      note_fail($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic check_err(input string name, input rx_bert_pkg::err_cnt_t got,
                           input rx_bert_pkg::err_cnt_t exp);
    n_checks++;
    if (got !== exp)
      note_fail($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic check_bits(input string name, input rx_bert_pkg::bit_cnt_t got,
                            input rx_bert_pkg::bit_cnt_t exp);
    n_checks++;
    if (got !== exp)
      note_fail($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp)
      note_fail($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic end_test(input string name);
    $display("test %-24s %s", name, (n_errors == err_mark) ? "ok" : "failed");
    err_mark = n_errors;
  endtask

  //--------------------------------------------------
  // Stimulus, one beat per falling edge
  //--------------------------------------------------
  task automatic tick();
    rx_bert_pkg::fifo_word_t w;
    rx_bert_pkg::lane_data_t b;
    logic                    nb;
    @(negedge m_rd_clk_g);
    w = $urandom;                                    // Other lanes random
    if (prbs_on)
    begin
      for (int i = 0; i < `LANE_W; i++)
      begin
        nb = (gen_order == 7) ? (gen_hist[5] ^ gen_hist[6]) : (gen_hist[13] ^ gen_hist[14]);
        gen_hist = {gen_hist[13:0], nb};
        b[i] = nb;
      end
      if (flip_on && (beat_cnt % 11 == 0))
        b[3] = ~b[3];                                // Chosen bit errors
      if (flip_on && (beat_cnt % 17 == 0))
        b[6] = ~b[6];
      w[gen_lane*`LANE_W +: `LANE_W] = b;
    end
    i_fifo_rdata = w;
    if (beat_cnt < LOG_DEPTH)
      lane_log[beat_cnt] = w[gen_lane*`LANE_W +: `LANE_W];
    beat_cnt++;
  endtask

  // One access; last_beat is the newest beat the read data covers
  task automatic run_access(input logic wr, input rx_bert_pkg::bert_addr_t addr,
                            input rx_bert_pkg::bert_word_t wdata,
                            output rx_bert_pkg::bert_word_t rdata, output int last_beat);
    int t;
    tick();
    i_bert_acc_req  = 1'b1;
    i_bert_acc_rdwr = wr;
    i_bert_acc_addr = addr;
    i_bert_wdata    = wdata;
    last_beat       = beat_cnt - 1;
    t = 0;
    do
    begin
      tick();
      t++;
    end
    while (!o_bert_acc_rq_pend && t < TMO);
    i_bert_acc_req = 1'b0;                           // One-cycle request pulse
    if (!o_bert_acc_rq_pend)
      note_fail($sformatf("timeout: access to 0x%0h never went pending", addr));
    t = 0;
    while (o_bert_acc_rq_pend && t < TMO)
    begin
      tick();
      t++;
    end
    if (o_bert_acc_rq_pend)
      note_fail($sformatf("timeout: pending flag for 0x%0h never cleared", addr));
    rdata = o_bert_rdata;
  endtask

  task automatic bus_read(input rx_bert_pkg::bert_addr_t addr,
                          output rx_bert_pkg::bert_word_t data, output int last_beat);
    run_access(1'b0, addr, '0, data, last_beat);
  endtask

  task automatic bus_write(input rx_bert_pkg::bert_addr_t addr,
                           input rx_bert_pkg::bert_word_t data);
    rx_bert_pkg::bert_word_t unused_rd;
    int                      unused_lb;
    run_access(1'b1, addr, data, unused_rd, unused_lb);
  endtask

  //--------------------------------------------------
  // Test sequence
  //--------------------------------------------------
  initial
  begin
    rx_bert_pkg::bert_word_t rd;
    rx_bert_pkg::fifo_word_t prev;
    rx_bert_pkg::err_cnt_t   e_exp;
    rx_bert_pkg::bit_cnt_t   b_exp;
    logic                    f_exp;
    int                      lb;
    int                      first;
    int                      pend_hits;
    void'($urandom(42));
    rxrd_fifo_rstn  = 1'b0;
    i_fifo_rdata    = '0;
    i_bert_acc_req  = 1'b0;
    i_bert_acc_rdwr = 1'b0;
    i_bert_acc_addr = '0;
    i_bert_wdata    = '0;
    repeat (2) tick();                               // Two cycles in reset
    rxrd_fifo_rstn = 1'b1;

    // 1 Reset values
    check_word("o_data_out_f", o_data_out_f, '0);
    check_flag("o_bert_acc_rq_pend", o_bert_acc_rq_pend, 1'b0);
    check_flag("o_rxbert_run", o_rxbert_run, 1'b0);
    check_flag("o_rxbert_biterr", o_rxbert_biterr, 1'b0);
    bus_read(`BERT_CTRL_ADDR, rd, lb);
    check_reg("ctrl", rd, '0);
    bus_read(`BERT_ERR_ADDR, rd, lb);
    check_reg("err", rd, '0);
    bus_read(`BERT_BITS_ADDR, rd, lb);
    check_reg("bits", rd, '0);
    bus_read(`BERT_STAT_ADDR, rd, lb);
    check_reg("stat", rd, '0);
    bus_read(6'h3f, rd, lb);                         // Unmapped
    check_reg("unmapped", rd, '0);
    end_test("reset values");

    // 2 FIFO-mode output register, one cycle late
    tick();
    prev = i_fifo_rdata;
    for (int n = 0; n < 50; n++)
    begin
      tick();
      check_word("o_data_out_f", o_data_out_f, prev);
      prev = i_fifo_rdata;
    end
    end_test("fifo output register");

    // 3 Clean PRBS7 on lane 2
    gen_order = 7;
    gen_lane  = 2;
    prbs_on   = 1'b1;
    bus_write(`BERT_CTRL_ADDR, 32'h21);              // Lane 2, PRBS7, start
    first = beat_cnt - 1;                            // First beat the checker takes
    repeat (20) tick();
    bus_read(`BERT_STAT_ADDR, rd, lb);
    check_reg("stat", rd, 32'h1);
    bus_read(`BERT_BITS_ADDR, rd, lb);
    prbs_ref_check(first, lb, 7, e_exp, b_exp, f_exp);
    check_bits("bit count", rd, b_exp);
    check_bits("bit count", rd, rx_bert_pkg::bit_cnt_t'(8*(lb-first+1)-7));
    bus_read(`BERT_ERR_ADDR, rd, lb);
    check_err("err count", rd[`ERR_CNT_W-1:0], '0);
    end_test("prbs7 clean lane 2");

    // 4 PRBS15 on lane 1 with flipped bits
    gen_order = 15;
    gen_lane  = 1;
    gen_hist  = 15'h5a3c;
    flip_on   = 1'b1;
    bus_write(`BERT_CTRL_ADDR, 32'h15);              // Lane 1, PRBS15, start
    first = beat_cnt - 1;
    repeat (40) tick();
    bus_read(`BERT_ERR_ADDR, rd, lb);
    prbs_ref_check(first, lb, 15, e_exp, b_exp, f_exp);
    check_err("err count", rd[`ERR_CNT_W-1:0], e_exp);
    bus_read(`BERT_BITS_ADDR, rd, lb);
    prbs_ref_check(first, lb, 15, e_exp, b_exp, f_exp);
    check_bits("bit count", rd, b_exp);
    bus_read(`BERT_STAT_ADDR, rd, lb);
    prbs_ref_check(first, lb, 15, e_exp, b_exp, f_exp);
    check_flag("stat run", rd[0], 1'b1);
    check_flag("stat biterr", rd[1], f_exp);
    end_test("prbs15 with errors");

    // 5 Checker reset, lane and pattern kept
    flip_on = 1'b0;
    bus_write(`BERT_CTRL_ADDR, 32'h16);              // Same lane/pattern plus reset
    check_flag("o_rxbert_run", o_rxbert_run, 1'b0);
    check_flag("o_rxbert_biterr", o_rxbert_biterr, 1'b0);
    bus_read(`BERT_STAT_ADDR, rd, lb);
    check_reg("stat", rd, '0);
    bus_read(`BERT_ERR_ADDR, rd, lb);
    check_reg("err", rd, '0);
    bus_read(`BERT_BITS_ADDR, rd, lb);
    check_reg("bits", rd, '0);
    bus_read(`BERT_CTRL_ADDR, rd, lb);
    check_reg("ctrl", rd, 32'h14);
    end_test("checker reset");

    // 6 Second request inside the pending cycle
    tick();
    i_bert_acc_req  = 1'b1;
    i_bert_acc_rdwr = 1'b1;
    i_bert_acc_addr = `BERT_CTRL_ADDR;
    i_bert_wdata    = 32'h34;                        // Lane 3, PRBS15
    pend_hits = 0;
    tick();
    if (o_bert_acc_rq_pend)
      pend_hits++;
    i_bert_wdata = 32'h00;                           // Must be dropped
    tick();
    i_bert_acc_req = 1'b0;
    for (int n = 0; n < 4; n++)
    begin
      if (o_bert_acc_rq_pend)
        pend_hits++;
      tick();
    end
    check_reg("pending pulses", pend_hits, 32'h1);
    bus_read(`BERT_CTRL_ADDR, rd, lb);
    check_reg("ctrl", rd, 32'h34);
    end_test("request while pending");

    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+hw
hw/rx_bert_pkg.sv
hw/rx_bert_acc_decode.sv
hw/rx_bert_checker.sv
hw/rx_bert_readback.sv
hw/rx_rd_adapter_top.sv
sim/rx_rd_adapter_assertions.sv
sim/rx_rd_adapter_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the RX read adapter testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
  -f src.f \
  --top-module rx_rd_adapter_tb \
  -o rx_rd_adapter_sim &&
./obj_dir/rx_rd_adapter_sim | tee /dev/stderr | grep -qF '*** PASSED ***' &&
echo "run_sim: simulation passed" ||
{
  echo "run_sim: simulation failed"
  exit 1
}
